//--- fc_defines.svh
`ifndef FC_DEFINES_SVH
`define FC_DEFINES_SVH

////////////////////
// layer geometry
////////////////////

`define FC_AF           3    // output lanes per weight word / result beat
`define FC_BATCH        2    // images in parallel
`define FC_FIN          8    // input features per vector
`define FC_FOUT         6    // output neurons, multiple of FC_AF
`define FC_GROUPS       (`FC_FOUT / `FC_AF)

////////////////////
// arithmetic
////////////////////

`define FC_DATA_W       8    // act, weight and result width
`define FC_PRECISION    4    // fractional bits dropped on requant
`define FC_ACC_W        24   // accumulator, plenty of headroom for FIN terms

// buffering
`define FC_WFIFO_DEPTH  16
`define FC_ADDR_W       3    // covers FC_FIN entries per bank

`endif

//--- fc_pkg.sv
`default_nettype none

`include "fc_defines.svh"

package fc_pkg;

  ////////////////////
  // stream payloads
  ////////////////////

  typedef logic signed [`FC_DATA_W-1:0] act_t;     // one int8 activation
  typedef act_t [`FC_BATCH-1:0] act_beat_t;        // one feature, every image

  typedef logic signed [`FC_DATA_W-1:0] weight_t;
  typedef weight_t [`FC_AF-1:0] weight_word_t;     // lane j -> neuron g*AF+j

  // requantized outputs of one image
  typedef logic [`FC_AF-1:0][`FC_DATA_W-1:0] lane_vec_t;

  typedef struct packed {
    logic [$clog2(`FC_GROUPS)-1:0] group;          // output group index
    lane_vec_t [`FC_BATCH-1:0]     lanes;          // indexed by image
  } result_t;

  ////////////////////
  // buffer write port
  ////////////////////

  typedef struct packed {
    logic                  en;
    logic [`FC_ADDR_W-1:0] addr;                   // feature index
    act_beat_t             data;
  } buf_wr_t;

endpackage

`default_nettype wire

//--- fc_weight_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "fc_defines.svh"

// first-word-fall-through weight buffer
module fc_weight_fifo (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid,
  input  fc_pkg::weight_word_t in_data,
  output logic                 in_ready,
  output logic                 out_valid,
  output fc_pkg::weight_word_t out_data,
  input  logic                 out_ready
);

  localparam int DEPTH = `FC_WFIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  fc_pkg::weight_word_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;    // one extra bit to hold DEPTH
  logic             push;
  logic             pop;

  assign in_ready  = (count != (PTR_W+1)'(DEPTH));   // low only when full
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];                    // fall-through head

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // storage array
  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= in_data;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;   // power-of-two depth wraps naturally
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  a_count_bound : assert property (@(posedge clk) disable iff (!rst_n)
    count <= (PTR_W+1)'(DEPTH));

endmodule

`default_nettype wire

//--- fc_act_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "fc_defines.svh"

// activation stream from the last conv stage into the filling bank
module fc_act_writer (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              act_valid,
  input  fc_pkg::act_beat_t act_data,
  output logic              act_ready,
  output fc_pkg::buf_wr_t   wr,
  output logic              fill_done,
  input  logic              fill_free
);

  logic [`FC_ADDR_W-1:0] feat_cnt;   // next feature index in the bank
  logic                  accept;
  logic                  last_beat;

  ////////////////////
  // handshake
  ////////////////////

  assign act_ready = fill_free;      // filling bank still has room
  assign accept    = act_valid && act_ready;
  assign last_beat = (feat_cnt == `FC_ADDR_W'(`FC_FIN-1));

  // final write and fill_done share a cycle
  assign fill_done = accept && last_beat;

  always_comb
  begin
    wr      = '0;
    wr.en   = accept;
    wr.addr = feat_cnt;
    wr.data = act_data;
  end

  ////////////////////
  // feature counter
  ////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      feat_cnt <= '0;
    else if (accept)
    begin
      if (last_beat)
        feat_cnt <= '0;              // wrap for the next vector
      else
        feat_cnt <= feat_cnt + 1'b1;
    end
  end

  // a started vector keeps its bank open until the last beat
  a_bank_open_mid_vector : assert property (@(posedge clk) disable iff (!rst_n)
    (feat_cnt != '0) |-> fill_free);

endmodule

`default_nettype wire

//--- fc_pingpong_buf.sv
`timescale 1ns/1ps
`default_nettype none

`include "fc_defines.svh"

// two activation banks, one filling while the other feeds the MAC engine
module fc_pingpong_buf (
  input  logic                  clk,
  input  logic                  rst_n,
  input  fc_pkg::buf_wr_t       wr,
  input  logic                  fill_done,
  input  logic                  bank_release,
  output logic                  fill_free,
  output logic                  comp_full,
  input  logic [`FC_ADDR_W-1:0] rd_addr,
  output fc_pkg::act_beat_t     rd_data
);

  fc_pkg::act_beat_t mem [2][`FC_FIN];   // [bank][feature]

  logic [1:0] full;        // one flag per bank
  logic       fill_ptr;    // bank being written
  logic       comp_ptr;    // bank being read

  ////////////////////
  // status
  ////////////////////

  assign fill_free = !full[fill_ptr];
  assign comp_full = full[comp_ptr];

  ////////////////////
  // banks
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (wr.en)
      mem[fill_ptr][wr.addr] <= wr.data;
  end

  // registered read, data one cycle after rd_addr
  always_ff @(posedge clk)
  begin
    rd_data <= mem[comp_ptr][rd_addr];
  end

  ////////////////////
  // pointers and flags
  ////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      full     <= '0;
      fill_ptr <= 1'b0;
      comp_ptr <= 1'b0;   // both start on bank 0
    end
    else
    begin
      // fill_done and bank_release never hit the same bank in one cycle,
      // one needs it empty, the other full
      if (fill_done)
      begin
        full[fill_ptr] <= 1'b1;
        fill_ptr       <= ~fill_ptr;
      end
      if (bank_release)
      begin
        full[comp_ptr] <= 1'b0;
        comp_ptr       <= ~comp_ptr;
      end
    end
  end

  // writer side must not close a bank that already holds a vector
  a_fill_into_empty : assert property (@(posedge clk) disable iff (!rst_n)
    fill_done |-> !full[fill_ptr]);

  // engine side must only release what it was computing on
  a_release_full : assert property (@(posedge clk) disable iff (!rst_n)
    bank_release |-> full[comp_ptr]);

endmodule

`default_nettype wire

//--- fc_mac_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "fc_defines.svh"

// issue -> read/multiply -> accumulate, one result beat per output group
module fc_mac_engine (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  comp_full,
  output logic [`FC_ADDR_W-1:0] rd_addr,
  input  fc_pkg::act_beat_t     rd_data,
  output logic                  bank_release,
  input  logic                  w_valid,
  input  fc_pkg::weight_word_t  w_data,
  output logic                  w_ready,
  output logic                  result_valid,
  output fc_pkg::result_t       result,
  input  logic                  result_ready
);

  localparam int GRP_W  = $clog2(`FC_GROUPS);
  localparam int PROD_W = 2 * `FC_DATA_W;
  localparam int MAX_Q  = 2 ** (`FC_DATA_W - 1) - 1;   // 127 for int8

  logic [`FC_ADDR_W-1:0] in_cnt;
  logic [GRP_W-1:0]      grp_cnt;
  logic                  issue;
  logic                  in_last;
  logic                  last_in_flight;

  // stage 1, waiting on rd_data
  logic                  s1_valid;
  logic                  s1_first;
  logic                  s1_last;
  logic [GRP_W-1:0]      s1_grp;
  fc_pkg::weight_word_t  s1_w;          // weight held to line up with rd_data

  // stage 2, products ready to add
  logic                  s2_valid;
  logic                  s2_first;
  logic                  s2_last;
  logic [GRP_W-1:0]      s2_grp;
  logic signed [PROD_W-1:0]    s2_prod [`FC_BATCH][`FC_AF];

  logic signed [`FC_ACC_W-1:0] acc [`FC_BATCH][`FC_AF];
  logic signed [`FC_ACC_W-1:0] sum [`FC_BATCH][`FC_AF];

  // shift out fraction, relu, clamp to int8
  function automatic logic [`FC_DATA_W-1:0] requant(input logic signed [`FC_ACC_W-1:0] s);
    logic signed [`FC_ACC_W-1:0] q;
    q = s >>> `FC_PRECISION;
    if (q < 0)
      return '0;
    else if (q > MAX_Q)
      return `FC_DATA_W'(MAX_Q);
    else
      return q[`FC_DATA_W-1:0];
  endfunction

  ////////////////////
  // issue
  ////////////////////

  // hold off while a group end is in flight or the output slot is taken
  assign last_in_flight = (s1_valid && s1_last) || (s2_valid && s2_last);
  assign issue   = comp_full && w_valid && !result_valid && !last_in_flight;
  assign w_ready = issue;               // pop weight with the read
  assign rd_addr = in_cnt;
  assign in_last = (in_cnt == `FC_ADDR_W'(`FC_FIN-1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      in_cnt  <= '0;
      grp_cnt <= '0;
    end
    else if (issue)
    begin
      if (in_last)
      begin
        in_cnt <= '0;
        if (grp_cnt == GRP_W'(`FC_GROUPS-1))
          grp_cnt <= '0;                // bank done, wait for release
        else
          grp_cnt <= grp_cnt + 1'b1;
      end
      else
        in_cnt <= in_cnt + 1'b1;
    end
  end

  ////////////////////
  // pipeline control
  ////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      s1_valid     <= 1'b0;
      s1_first     <= 1'b0;
      s1_last      <= 1'b0;
      s2_valid     <= 1'b0;
      s2_first     <= 1'b0;
      s2_last      <= 1'b0;
      result_valid <= 1'b0;
    end
    else
    begin
      s1_valid <= issue;
      s1_first <= issue && (in_cnt == '0);
      s1_last  <= issue && in_last;
      s2_valid <= s1_valid;
      s2_first <= s1_first;
      s2_last  <= s1_last;
      if (s2_valid && s2_last)
        result_valid <= 1'b1;
      else if (result_ready)
        result_valid <= 1'b0;
    end
  end

  // datapath, payload only
  always_ff @(posedge clk)
  begin
    s1_w   <= w_data;
    s1_grp <= grp_cnt;
    s2_grp <= s1_grp;
    for (int b = 0; b < `FC_BATCH; b++)
      for (int j = 0; j < `FC_AF; j++)
        s2_prod[b][j] <= $signed(rd_data[b]) * $signed(s1_w[j]);
  end

  ////////////////////
  // accumulate and requant
  ////////////////////

  always_comb
  begin
    for (int b = 0; b < `FC_BATCH; b++)
      for (int j = 0; j < `FC_AF; j++)
        if (s2_first)
          sum[b][j] = s2_prod[b][j];    // first input of a group clears
        else
          sum[b][j] = acc[b][j] + s2_prod[b][j];
  end

  always_ff @(posedge clk)
  begin
    if (s2_valid)
      acc <= sum;
    if (s2_valid && s2_last)
    begin
      result.group <= s2_grp;
      for (int b = 0; b < `FC_BATCH; b++)
        for (int j = 0; j < `FC_AF; j++)
          result.lanes[b][j] <= requant(sum[b][j]);
    end
  end

  // bank is free once the final group has left
  assign bank_release = result_valid && result_ready
                        && (result.group == GRP_W'(`FC_GROUPS-1));

  a_result_hold : assert property (@(posedge clk) disable iff (!rst_n)
    result_valid && !result_ready |=> result_valid && $stable(result));

endmodule

`default_nettype wire

//--- fc_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fc_defines.svh"

// single fully connected layer: act writer, ping-pong buffer, weight FIFO, MAC
module fc_top (
  input  logic                 clk,
  input  logic                 rst_n,
  // activations from last conv stage
  input  logic                 act_valid,
  input  fc_pkg::act_beat_t    act_data,
  output logic                 act_ready,
  // weight words, group-major then input
  input  logic                 weight_valid,
  input  fc_pkg::weight_word_t weight_data,
  output logic                 weight_ready,
  // results, one beat per group
  output logic                 result_valid,
  output fc_pkg::result_t      result,
  input  logic                 result_ready
);

  ////////////////////
  // internal nets
  ////////////////////

  fc_pkg::buf_wr_t       wr;
  logic                  fill_done;
  logic                  fill_free;
  logic                  comp_full;
  logic                  bank_release;
  logic [`FC_ADDR_W-1:0] rd_addr;
  fc_pkg::act_beat_t     rd_data;
  logic                  w_valid;
  fc_pkg::weight_word_t  w_data;
  logic                  w_ready;

  fc_weight_fifo u_weight_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (weight_valid),
    .in_data   (weight_data),
    .in_ready  (weight_ready),
    .out_valid (w_valid),
    .out_data  (w_data),
    .out_ready (w_ready)
  );

  fc_act_writer u_act_writer (
    .clk       (clk),
    .rst_n     (rst_n),
    .act_valid (act_valid),
    .act_data  (act_data),
    .act_ready (act_ready),
    .wr        (wr),
    .fill_done (fill_done),
    .fill_free (fill_free)
  );

  fc_pingpong_buf u_pingpong_buf (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr           (wr),
    .fill_done    (fill_done),
    .bank_release (bank_release),
    .fill_free    (fill_free),
    .comp_full    (comp_full),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data)
  );

  fc_mac_engine u_mac_engine (
    .clk          (clk),
    .rst_n        (rst_n),
    .comp_full    (comp_full),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),      // one cycle behind rd_addr
    .bank_release (bank_release),
    .w_valid      (w_valid),
    .w_data       (w_data),
    .w_ready      (w_ready),
    .result_valid (result_valid),
    .result       (result),
    .result_ready (result_ready)
  );

endmodule

`default_nettype wire

//--- tb_fc_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fc_defines.svh"

module tb_fc_top;

  localparam int CLK_HALF = 20;                      // 40 ns period
  localparam int N_WORDS  = `FC_GROUPS * `FC_FIN;    // weight words per vector

  logic                 clk;
  logic                 rst_n;
  logic                 act_valid;
  fc_pkg::act_beat_t    act_data;
  logic                 act_ready;
  logic                 weight_valid;
  fc_pkg::weight_word_t weight_data;
  logic                 weight_ready;
  logic                 result_valid;
  fc_pkg::result_t      result;
  logic                 result_ready;

  ////////////////////
  // cases flattened over all tests
  ////////////////////

  fc_pkg::act_beat_t    act_q [$];
  fc_pkg::weight_word_t wt_q [$];
  fc_pkg::result_t      exp_q [$];
  logic [8*24-1:0]      name_q [$];
  int                   mode_q [$];    // 0 plain, 1 weights held, 2 random ready
  int                   nvec_q [$];    // vectors per test

  int   n_tests;
  int   err_cnt;
  int   fail_tests;
  logic loaded;
  logic load_ok;

  always #CLK_HALF clk = ~clk;

  fc_top UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .act_valid    (act_valid),
    .act_data     (act_data),
    .act_ready    (act_ready),
    .weight_valid (weight_valid),
    .weight_data  (weight_data),
    .weight_ready (weight_ready),
    .result_valid (result_valid),
    .result       (result),
    .result_ready (result_ready)
  );

  task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp)
    begin
      err_cnt++;
      $display("FAILED at %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // drive point 2 ns after the rising edge
  task automatic wait_drive_point();
    @(posedge clk);
    #2;
  endtask

  task automatic report_test(input logic [8*24-1:0] name, input int errs_before);
    if (err_cnt == errs_before)
      $display("test %0s: ok", name);
    else
    begin
      fail_tests++;
      $display("test %0s: %0d errors", name, err_cnt - errs_before);
    end
  endtask

  ////////////////////
  // cases file
  ////////////////////

  task automatic load_cases();
    int                   fd;
    int                   rc;
    int                   val;
    int                   mode;
    int                   n_a;
    int                   n_w;
    int                   n_r;
    logic                 short_read;
    logic [8*8-1:0]       tag;
    logic [8*24-1:0]      name;
    logic [8*128-1:0]     line;
    fc_pkg::act_beat_t    beat;
    fc_pkg::weight_word_t word;
    fc_pkg::result_t      res;
    short_read = 1'b0;
    fd = $fopen("fc_cases.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open fc_cases.txt, no tests were run");
      err_cnt++;
    end
    else
    begin
      load_ok = 1'b1;
      while ($fscanf(fd, "%s", tag) == 1)
      begin
        if (tag == "#")
          void'($fgets(line, fd));                    // column notes
        else if (tag == "T")
        begin
          rc  = $fscanf(fd, "%s %d", name, mode);
          if (rc != 2)
            short_read = 1'b1;
          n_a = 0;
          n_w = 0;
          n_r = 0;
        end
        else if (tag == "A")
        begin
          for (int k = 0; k < `FC_FIN; k++)
          begin
            for (int b = 0; b < `FC_BATCH; b++)
            begin
              rc      = $fscanf(fd, "%d", val);
              if (rc != 1)
                short_read = 1'b1;
              beat[b] = val[`FC_DATA_W-1:0];
            end
            act_q.push_back(beat);
          end
          n_a++;
        end
        else if (tag == "W")
        begin
          for (int i = 0; i < `FC_FIN; i++)
          begin
            for (int j = 0; j < `FC_AF; j++)
            begin
              rc      = $fscanf(fd, "%d", val);
              if (rc != 1)
                short_read = 1'b1;
              word[j] = val[`FC_DATA_W-1:0];
            end
            wt_q.push_back(word);
          end
          n_w++;
        end
        else if (tag == "R")
        begin
          rc        = $fscanf(fd, "%d", val);
          if (rc != 1)
            short_read = 1'b1;
          res.group = val[0];
          for (int b = 0; b < `FC_BATCH; b++)
            for (int j = 0; j < `FC_AF; j++)
            begin
              rc              = $fscanf(fd, "%d", val);
              if (rc != 1)
                short_read = 1'b1;
              res.lanes[b][j] = val[`FC_DATA_W-1:0];
            end
          exp_q.push_back(res);
          n_r++;
        end
        else if (tag == "E")
        begin
          if (n_w != n_a * `FC_GROUPS || n_r != n_a * `FC_GROUPS)
          begin
            $display("cases file: test %0s has weight or result lines that do not fit", name);
            load_ok = 1'b0;
            err_cnt++;
          end
          name_q.push_back(name);
          mode_q.push_back(mode);
          nvec_q.push_back(n_a);
          n_tests++;
        end
        else
        begin
          $display("cases file: unknown line tag %0s", tag);
          load_ok = 1'b0;
          err_cnt++;
        end
      end
      if (short_read)
      begin
        $display("cases file: a line ends before all its values were read");
        load_ok = 1'b0;
        err_cnt++;
      end
      $fclose(fd);
    end
  endtask

  ////////////////////
  // stream drivers
  ////////////////////

  task automatic send_acts(input int nvec);
    for (int k = 0; k < nvec * `FC_FIN; k++)
    begin
      act_valid = 1'b1;
      act_data  = act_q.pop_front();
      while (!act_ready)
        wait_drive_point();
      wait_drive_point();                            // taken at this edge
    end
    act_valid = 1'b0;
  endtask

  task automatic send_weights(input int nvec);
    for (int k = 0; k < nvec * N_WORDS; k++)
    begin
      weight_valid = 1'b1;
      weight_data  = wt_q.pop_front();
      while (!weight_ready)
        wait_drive_point();
      wait_drive_point();
    end
    weight_valid = 1'b0;
  endtask

  task automatic collect_results(input int n, input bit rand_ready);
    fc_pkg::result_t exp;
    int              got_n;
    got_n = 0;
    while (got_n < n)
    begin
      result_ready = rand_ready ? 1'($urandom % 2) : 1'b1;
      if (result_valid && result_ready)
      begin
        exp = exp_q.pop_front();
        check_val(result.group, exp.group, $sformatf("result %0d group", got_n));
        for (int b = 0; b < `FC_BATCH; b++)
          for (int j = 0; j < `FC_AF; j++)
            check_val(result.lanes[b][j], exp.lanes[b][j],
                      $sformatf("result %0d image %0d lane %0d", got_n, b, j));
        got_n++;
      end
      wait_drive_point();
    end
    result_ready = 1'b0;
  endtask

  task automatic run_test(input logic [8*24-1:0] name, input int mode, input int nvec);
    int errs_before;
    errs_before = err_cnt;
    if (mode == 1)
    begin
      send_acts(nvec);                               // no weights yet so both banks fill
      act_valid = 1'b1;                              // third vector knocks
      act_data  = '0;
      for (int c = 0; c < 8; c++)
      begin
        check_val(act_ready, 1'b0, "act_ready with both banks full");
        wait_drive_point();
      end
      act_valid = 1'b0;
      fork
        send_weights(nvec);
        collect_results(nvec * `FC_GROUPS, 1'b0);
      join
    end
    else
    begin
      fork
        send_acts(nvec);
        send_weights(nvec);
        collect_results(nvec * `FC_GROUPS, mode == 2);
      join
    end
    result_ready = 1'b1;                             // any extra beat shows up here
    for (int c = 0; c < 8; c++)
    begin
      check_val(result_valid, 1'b0, "extra result beat after the last one");
      wait_drive_point();
    end
    result_ready = 1'b0;
    report_test(name, errs_before);
  endtask

  task automatic check_reset_state();
    int errs_before;
    errs_before = err_cnt;
    check_val(result_valid, 1'b0, "result_valid after reset");
    check_val(act_ready, 1'b1, "act_ready after reset");
    check_val(weight_ready, 1'b1, "weight_ready after reset");
    report_test("reset", errs_before);
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial
  begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    act_valid    = 1'b0;
    act_data     = '0;
    weight_valid = 1'b0;
    weight_data  = '0;
    result_ready = 1'b0;
    err_cnt      = 0;
    fail_tests   = 0;
    n_tests      = 0;
    load_ok      = 1'b0;
    loaded       = 1'b0;
    void'($urandom(22653));                          // one seed for the run
    load_cases();
    loaded = 1'b1;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    wait_drive_point();
    if (load_ok)
    begin
      check_reset_state();
      for (int t = 0; t < n_tests; t++)
        run_test(name_q[t], mode_q[t], nvec_q[t]);
    end
    $display("summary: %0d tests, %0d failed, %0d check errors",
             n_tests + 1, fail_tests, err_cnt);
    if (load_ok && err_cnt == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

  // watchdog budget scales with the test count
  initial
  begin
    wait (loaded);
    #((n_tests + 1) * (N_WORDS + 64) * 2 * CLK_HALF);
    $display("timeout: the tests did not finish in time, stopped at %0t ns", $time);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- fc_cases.txt
# T name mode, mode 0 plain, 1 weights held back, 2 random result_ready
# A one vector, per feature image 0 then image 1; W one group, per input lanes 0 1 2
# R group, then image 0 lanes 0 1 2, then image 1 lanes 0 1 2; E closes the test
T basic 0
A 1 2  2 2  3 2  4 2  5 2  6 2  7 2  8 2
W 2 1 4  2 2 4  2 3 4  2 4 4  2 5 4  2 6 4  2 7 4  2 8 4
W 8 1 10  7 1 10  6 1 10  5 1 10  4 1 10  3 1 10  2 1 10  1 1 10
R 0  4 12 9  2 4 4
R 1  7 2 22  4 1 10
E
T clamp 0
A 100 -50  100 -50  100 -50  100 -50  100 -50  100 -50  100 -50  100 -50
W 10 -10 1  10 -10 1  10 -10 1  10 -10 1  10 -10 1  10 -10 1  10 -10 1  10 -10 1
W 127 -128 -1  127 -128 -1  127 -128 -1  127 -128 -1  127 -128 -1  127 -128 -1  127 -128 -1  127 -128 -1
R 0  127 0 50  0 127 0
R 1  127 0 0  0 127 25
E
T pingpong 1
A 16 32  16 32  16 32  16 32  16 32  16 32  16 32  16 32
W 1 2 3  1 2 3  1 2 3  1 2 3  1 2 3  1 2 3  1 2 3  1 2 3
W -1 4 0  -1 4 0  -1 4 0  -1 4 0  -1 4 0  -1 4 0  -1 4 0  -1 4 0
R 0  8 16 24  16 32 48
R 1  0 32 0  0 64 0
A 1 4  2 4  3 4  4 4  5 4  6 4  7 4  8 4
W 1 2 -2  2 2 -2  3 2 -2  4 2 -2  5 2 -2  6 2 -2  7 2 -2  8 2 -2
W 5 8 3  5 7 3  5 6 3  5 5 3  5 4 3  5 3 3  5 2 3  5 1 3
R 0  12 4 0  9 4 0
R 1  11 7 6  10 9 6
E
T backpressure 2
A -1 10  2 10  -3 10  4 10  -5 10  6 10  -7 10  8 10
W 1 1 -1  1 2 -1  1 3 -1  1 4 -1  1 5 -1  1 6 -1  1 7 -1  1 8 -1
W 16 -8 9  16 8 9  16 -8 9  16 8 9  16 -8 9  16 8 9  16 -8 9  16 8 9
R 0  0 2 0  5 22 0
R 1  4 18 2  80 0 45
A 7 0  7 1  7 2  7 3  7 4  7 5  7 6  7 7
W 20 3 1  20 3 2  20 3 3  20 3 4  20 3 5  20 3 6  20 3 7  20 3 8
W -3 50 2  -3 50 2  -3 50 2  -3 50 2  -3 50 2  -3 50 2  -3 50 2  -3 50 2
R 0  70 10 15  35 5 10
R 1  0 127 7  0 87 3
E

//--- flist.f
+incdir+.
fc_pkg.sv
fc_weight_fifo.sv
fc_act_writer.sv
fc_pingpong_buf.sv
fc_mac_engine.sv
fc_top.sv
tb_fc_top.sv

//--- Bender.yml
package:
  name: fc_layer

export_include_dirs:
  - .

sources:
  - fc_pkg.sv
  - fc_weight_fifo.sv
  - fc_act_writer.sv
  - fc_pingpong_buf.sv
  - fc_mac_engine.sv
  - fc_top.sv
  - target: test
    files:
      - tb_fc_top.sv
